//--- include/rv_pipe_settings.svh
`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

// data, pc and immediate width.
`define XLEN 32

// register file address width, shared by the integer and float files.
`define REG_AW 5

// performance counter width.
`define CNT_W 64

`endif

//--- design/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    typedef enum logic [6:0] {
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_op       = 7'b0110011,
        op_imm      = 7'b0010011,
        op_branch   = 7'b1100011,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_load_fp  = 7'b0000111,
        op_store_fp = 7'b0100111,
        op_fp       = 7'b1010011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add     = 3'd0, // address and link arithmetic.
        alu_sub_cmp = 3'd1,
        alu_rtype   = 3'd2, // funct3/funct7 pick the operation.
        alu_itype   = 3'd3, // funct3 picks the operation.
        alu_lui     = 3'd4, // operand b passes straight through.
        alu_branch  = 3'd5  // compare for a conditional branch.
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_cond = 2'd1,
        br_jal  = 2'd2,
        br_jalr = 2'd3
    } branch_e;

    typedef enum logic [1:0] {
        ev_flush  = 2'd0,
        ev_stall  = 2'd1,
        ev_normal = 2'd2
    } pipe_event_e;

endpackage

`default_nettype wire

//--- design/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module id_decoder import rv_pipe_pkg::*; (
    input  logic [31:0]        instr,
    input  logic [`XLEN-1:0]   pc,
    output logic [`REG_AW-1:0] rs1_addr,
    output logic [`REG_AW-1:0] rs2_addr,
    output logic [`REG_AW-1:0] rd_addr,
    output logic               uses_frs1,
    output logic               uses_frs2,
    output logic [2:0]         funct3,
    output logic [6:0]         funct7,
    output logic [`XLEN-1:0]   imm,
    output alu_op_e            alu_op,
    output logic               alu_src,
    output logic               pc_to_reg,
    output logic               rd_src,
    output logic               mem_to_reg,
    output logic               mem_write,
    output logic               mem_read,
    output logic               reg_write,
    output logic               freg_write,
    output logic               alu_sel_f,
    output branch_e            branch,
    output logic               is_float,
    output logic               mem_in_f
);

    opcode_e          opcode;
    logic             reads_rs1;
    logic             reads_rs2;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign opcode  = opcode_e'(instr[6:0]);
    assign rd_addr = instr[11:7];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];

    // a slot the instruction does not read shows up as x0.
    assign rs1_addr = reads_rs1 ? instr[19:15] : '0;
    assign rs2_addr = reads_rs2 ? instr[24:20] : '0;

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                    1'b0};

    assign reads_rs1 = (opcode == op_load) || (opcode == op_store) || (opcode == op_op) ||
                       (opcode == op_imm) || (opcode == op_branch) || (opcode == op_jalr) ||
                       (opcode == op_load_fp) || (opcode == op_store_fp) || (opcode == op_fp);
    assign reads_rs2 = (opcode == op_store) || (opcode == op_op) || (opcode == op_branch) ||
                       (opcode == op_store_fp) || (opcode == op_fp);
    assign uses_frs1 = opcode == op_fp;
    assign uses_frs2 = (opcode == op_store_fp) || (opcode == op_fp);

    assign mem_read   = (opcode == op_load) || (opcode == op_load_fp);
    assign mem_to_reg = mem_read;
    assign mem_write  = (opcode == op_store) || (opcode == op_store_fp);
    assign mem_in_f   = opcode == op_store_fp; // store data comes from the float file.
    assign reg_write  = (opcode == op_load) || (opcode == op_op) || (opcode == op_imm) ||
                        (opcode == op_jal) || (opcode == op_jalr) || (opcode == op_lui) ||
                        (opcode == op_auipc);
    assign freg_write = (opcode == op_load_fp) || (opcode == op_fp);
    assign alu_src    = mem_read || mem_write || (opcode == op_imm) || (opcode == op_jalr) ||
                        (opcode == op_lui) || (opcode == op_auipc);
    assign pc_to_reg  = (opcode == op_branch) || (opcode == op_jal); // target is pc + imm.
    assign rd_src     = (opcode == op_jal) || (opcode == op_jalr); // rd takes the link pc.
    assign is_float   = opcode == op_fp;
    assign alu_sel_f  = opcode == op_fp;

    always_comb begin
        imm    = '0;
        alu_op = alu_add;
        branch = br_none;
        case (opcode)
            op_load, op_load_fp, op_jalr: imm = imm_i;
            op_store, op_store_fp:        imm = imm_s;
            op_imm: begin
                imm    = imm_i;
                alu_op = alu_itype;
            end
            op_op:  alu_op = alu_rtype;
            op_branch: begin
                imm    = imm_b;
                alu_op = alu_branch;
            end
            op_jal: imm = imm_j;
            op_lui: begin
                imm    = imm_u;
                alu_op = alu_lui;
            end
            op_auipc: begin
                imm    = pc + imm_u; // resolved here so execute passes it like lui.
                alu_op = alu_lui;
            end
            default: ;
        endcase
        case (opcode)
            op_branch: branch = br_cond;
            op_jal:    branch = br_jal;
            op_jalr:   branch = br_jalr;
            default:   branch = br_none;
        endcase
    end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module hazard_unit import rv_pipe_pkg::*; (
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic               uses_frs1,
    input  logic               uses_frs2,
    input  logic               mem_read_ex,
    input  logic [`REG_AW-1:0] write_addr_ex,
    input  logic               branch_taken,
    output logic               stall,
    output logic               bubble,
    output pipe_event_e        pipe_event
);

    logic dest_live;
    logic hit_rs1;
    logic hit_rs2;
    logic load_use;

    assign dest_live = write_addr_ex != '0; // a load to x0 never lands.

    // the feedback carries no file tag, so an address match across files stalls as well.
    assign hit_rs1  = (rs1_addr == write_addr_ex) && dest_live;
    assign hit_rs2  = (rs2_addr == write_addr_ex) && dest_live;
    assign load_use = mem_read_ex && (hit_rs1 || hit_rs2);

    always_comb begin
        if (branch_taken) begin
            bubble     = 1'b1; // squash the wrong-path instruction.
            stall      = 1'b0;
            pipe_event = ev_flush;
        end else if (load_use) begin
            bubble     = 1'b1;
            stall      = 1'b1; // fetch holds instr and pc.
            pipe_event = ev_stall;
        end else begin
            bubble     = 1'b0;
            stall      = 1'b0;
            pipe_event = ev_normal;
        end
    end

endmodule

`default_nettype wire

//--- design/idexe_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module idexe_reg import rv_pipe_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               bubble,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    input  logic [`XLEN-1:0]   frs1_data,
    input  logic [`XLEN-1:0]   frs2_data,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic [`REG_AW-1:0] rd_addr,
    input  logic               uses_frs1,
    input  logic               uses_frs2,
    input  logic [2:0]         funct3,
    input  logic [6:0]         funct7,
    input  logic [`XLEN-1:0]   imm,
    input  alu_op_e            alu_op,
    input  logic               alu_src,
    input  logic               pc_to_reg,
    input  logic               rd_src,
    input  logic               mem_to_reg,
    input  logic               mem_write,
    input  logic               mem_read,
    input  logic               reg_write,
    input  logic               freg_write,
    input  logic               alu_sel_f,
    input  branch_e            branch,
    input  logic               is_float,
    input  logic               mem_in_f,
    output logic [`XLEN-1:0]   ex_pc,
    output logic [`XLEN-1:0]   ex_rs1_data,
    output logic [`XLEN-1:0]   ex_rs2_data,
    output logic [`XLEN-1:0]   ex_frs1_data,
    output logic [`XLEN-1:0]   ex_frs2_data,
    output logic [`REG_AW-1:0] ex_rs1_addr,
    output logic [`REG_AW-1:0] ex_rs2_addr,
    output logic [`REG_AW-1:0] ex_rd_addr,
    output logic               ex_uses_frs1,
    output logic               ex_uses_frs2,
    output logic [2:0]         ex_funct3,
    output logic [6:0]         ex_funct7,
    output logic [`XLEN-1:0]   ex_imm,
    output alu_op_e            ex_alu_op,
    output logic               ex_alu_src,
    output logic               ex_pc_to_reg,
    output logic               ex_rd_src,
    output logic               ex_mem_to_reg,
    output logic               ex_mem_write,
    output logic               ex_mem_read,
    output logic               ex_reg_write,
    output logic               ex_freg_write,
    output logic               ex_alu_sel_f,
    output branch_e            ex_branch,
    output logic               ex_is_float,
    output logic               ex_mem_in_f
);

    localparam int pay_w = 6 * `XLEN + 3 * `REG_AW + 23;

    logic [pay_w-1:0] stage_d;
    logic [pay_w-1:0] stage_q;

    assign stage_d = bubble ? '0 : {pc, rs1_data, rs2_data, frs1_data, frs2_data, imm,
                                    rs1_addr, rs2_addr, rd_addr, funct3, funct7,
                                    uses_frs1, uses_frs2, alu_src, pc_to_reg, rd_src,
                                    mem_to_reg, mem_write, mem_read, reg_write, freg_write,
                                    alu_sel_f, is_float, mem_in_f};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_q   <= '0;
            ex_alu_op <= alu_add;
            ex_branch <= br_none;
        end else begin
            stage_q   <= stage_d;
            ex_alu_op <= bubble ? alu_add : alu_op; // a bubble is an all-zero nop.
            ex_branch <= bubble ? br_none : branch;
        end
    end

    assign {ex_pc, ex_rs1_data, ex_rs2_data, ex_frs1_data, ex_frs2_data, ex_imm,
            ex_rs1_addr, ex_rs2_addr, ex_rd_addr, ex_funct3, ex_funct7,
            ex_uses_frs1, ex_uses_frs2, ex_alu_src, ex_pc_to_reg, ex_rd_src,
            ex_mem_to_reg, ex_mem_write, ex_mem_read, ex_reg_write, ex_freg_write,
            ex_alu_sel_f, ex_is_float, ex_mem_in_f} = stage_q;

endmodule

`default_nettype wire

//--- design/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module perf_counters import rv_pipe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  pipe_event_e       pipe_event,
    output logic [`CNT_W-1:0] cycle_cnt,
    output logic [`CNT_W-1:0] instr_cnt
);

    localparam logic [`CNT_W-1:0] cnt_one = 'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_cnt <= '0;
            instr_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + cnt_one;
            // nothing has reached decode during the first two cycles.
            if (cycle_cnt > cnt_one) begin
                case (pipe_event)
                    ev_flush: instr_cnt <= instr_cnt - cnt_one; // the squashed fetch is undone.
                    ev_stall: instr_cnt <= instr_cnt;
                    default:  instr_cnt <= instr_cnt + cnt_one;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/id_stage_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module id_stage_top import rv_pipe_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        instr,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    input  logic [`XLEN-1:0]   frs1_data,
    input  logic [`XLEN-1:0]   frs2_data,
    input  logic               branch_taken,
    output logic               stall,
    output logic [`CNT_W-1:0]  cycle_cnt,
    output logic [`CNT_W-1:0]  instr_cnt,
    output logic [`XLEN-1:0]   ex_pc,
    output logic [`XLEN-1:0]   ex_rs1_data,
    output logic [`XLEN-1:0]   ex_rs2_data,
    output logic [`XLEN-1:0]   ex_frs1_data,
    output logic [`XLEN-1:0]   ex_frs2_data,
    output logic [`REG_AW-1:0] ex_rs1_addr,
    output logic [`REG_AW-1:0] ex_rs2_addr,
    output logic [`REG_AW-1:0] ex_rd_addr,
    output logic               ex_uses_frs1,
    output logic               ex_uses_frs2,
    output logic [2:0]         ex_funct3,
    output logic [6:0]         ex_funct7,
    output logic [`XLEN-1:0]   ex_imm,
    output alu_op_e            ex_alu_op,
    output logic               ex_alu_src,
    output logic               ex_pc_to_reg,
    output logic               ex_rd_src,
    output logic               ex_mem_to_reg,
    output logic               ex_mem_write,
    output logic               ex_mem_read,
    output logic               ex_reg_write,
    output logic               ex_freg_write,
    output logic               ex_alu_sel_f,
    output branch_e            ex_branch,
    output logic               ex_is_float,
    output logic               ex_mem_in_f
);

    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`REG_AW-1:0] rd_addr;
    logic               uses_frs1;
    logic               uses_frs2;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`XLEN-1:0]   imm;
    alu_op_e            alu_op;
    logic               alu_src;
    logic               pc_to_reg;
    logic               rd_src;
    logic               mem_to_reg;
    logic               mem_write;
    logic               mem_read;
    logic               reg_write;
    logic               freg_write;
    logic               alu_sel_f;
    branch_e            branch;
    logic               is_float;
    logic               mem_in_f;
    logic               bubble;
    pipe_event_e        pipe_event;

    id_decoder u_decoder (.*);

    // the load in execute is seen through the registered stage outputs.
    hazard_unit u_hazard (
        .mem_read_ex   (ex_mem_read),
        .write_addr_ex (ex_rd_addr),
        .*
    );

    idexe_reg u_idexe (.*);

    perf_counters u_perf (.*);

endmodule

`default_nettype wire

//--- tb/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module tb_id_stage import rv_pipe_pkg::*; ();

    logic               clk;
    logic               reset;
    logic [31:0]        instr;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   frs1_data;
    logic [`XLEN-1:0]   frs2_data;
    logic               branch_taken;
    logic               stall;
    logic [`CNT_W-1:0]  cycle_cnt;
    logic [`CNT_W-1:0]  instr_cnt;
    logic [`XLEN-1:0]   ex_pc;
    logic [`XLEN-1:0]   ex_rs1_data;
    logic [`XLEN-1:0]   ex_rs2_data;
    logic [`XLEN-1:0]   ex_frs1_data;
    logic [`XLEN-1:0]   ex_frs2_data;
    logic [`REG_AW-1:0] ex_rs1_addr;
    logic [`REG_AW-1:0] ex_rs2_addr;
    logic [`REG_AW-1:0] ex_rd_addr;
    logic               ex_uses_frs1;
    logic               ex_uses_frs2;
    logic [2:0]         ex_funct3;
    logic [6:0]         ex_funct7;
    logic [`XLEN-1:0]   ex_imm;
    alu_op_e            ex_alu_op;
    logic               ex_alu_src;
    logic               ex_pc_to_reg;
    logic               ex_rd_src;
    logic               ex_mem_to_reg;
    logic               ex_mem_write;
    logic               ex_mem_read;
    logic               ex_reg_write;
    logic               ex_freg_write;
    logic               ex_alu_sel_f;
    branch_e            ex_branch;
    logic               ex_is_float;
    logic               ex_mem_in_f;

    // expected decode, flags packed as uses_frs1 down to mem_in_f.
    logic [`REG_AW-1:0] e_rs1;
    logic [`REG_AW-1:0] e_rs2;
    logic [`REG_AW-1:0] e_rd;
    logic [2:0]         e_f3;
    logic [6:0]         e_f7;
    logic [`XLEN-1:0]   e_imm;
    alu_op_e            e_alu_op;
    branch_e            e_branch;
    logic [12:0]        e_flags;
    logic [`XLEN-1:0]   cur_pc;
    logic [`XLEN-1:0]   cur_d1;
    logic [`XLEN-1:0]   cur_d2;
    logic [`XLEN-1:0]   cur_d3;
    logic [`XLEN-1:0]   cur_d4;
    logic [`CNT_W-1:0]  edges;
    logic [`CNT_W-1:0]  sum;
    int                 pending;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;

    localparam logic [12:0] f_ufrs1 = 13'h1000;
    localparam logic [12:0] f_ufrs2 = 13'h0800;
    localparam logic [12:0] f_asrc  = 13'h0400;
    localparam logic [12:0] f_pcreg = 13'h0200;
    localparam logic [12:0] f_rdsrc = 13'h0100;
    localparam logic [12:0] f_m2r   = 13'h0080;
    localparam logic [12:0] f_mw    = 13'h0040;
    localparam logic [12:0] f_mr    = 13'h0020;
    localparam logic [12:0] f_rw    = 13'h0010;
    localparam logic [12:0] f_frw   = 13'h0008;
    localparam logic [12:0] f_self  = 13'h0004;
    localparam logic [12:0] f_isf   = 13'h0002;
    localparam logic [12:0] f_minf  = 13'h0001;

    id_stage_top UUT (.*);

    always #2 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic present(input logic [31:0] w, input logic bt);
        @(posedge clk);
        instr        <= w;
        branch_taken <= bt;
    endtask

    task automatic set_operands(input logic [31:0] pcv, d1, d2, d3, d4);
        cur_pc    = pcv;
        cur_d1    = d1;
        cur_d2    = d2;
        cur_d3    = d3;
        cur_d4    = d4;
        pc        <= pcv;
        rs1_data  <= d1;
        rs2_data  <= d2;
        frs1_data <= d3;
        frs2_data <= d4;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset        <= 1'b1;
        instr        <= '0;
        branch_taken <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (stall === 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (stall === 1'b1) begin
            $display("timeout: stall did not drop within 8 cycles");
            $display("TB FAILED");
            $finish;
        end
    endtask

    task automatic clear_expect();
        e_rs1    = '0;
        e_rs2    = '0;
        e_rd     = '0;
        e_f3     = '0;
        e_f7     = '0;
        e_imm    = '0;
        e_alu_op = alu_add;
        e_branch = br_none;
        e_flags  = '0;
    endtask

    task automatic ref_decode(input logic [31:0] w);
        clear_expect();
        e_rd = w[11:7];
        e_f3 = w[14:12];
        e_f7 = w[31:25];
        case (w[6:0])
            7'b0010011: begin
                e_rs1    = w[19:15];
                e_imm    = {{20{w[31]}}, w[31:20]};
                e_alu_op = alu_itype;
                e_flags  = f_asrc | f_rw;
            end
            7'b0110011: begin
                e_rs1    = w[19:15];
                e_rs2    = w[24:20];
                e_alu_op = alu_rtype;
                e_flags  = f_rw;
            end
            7'b0000011: begin
                e_rs1   = w[19:15];
                e_imm   = {{20{w[31]}}, w[31:20]};
                e_flags = f_asrc | f_m2r | f_mr | f_rw;
            end
            7'b0100011: begin
                e_rs1   = w[19:15];
                e_rs2   = w[24:20];
                e_imm   = {{20{w[31]}}, w[31:25], w[11:7]};
                e_flags = f_asrc | f_mw;
            end
            7'b1100011: begin
                e_rs1    = w[19:15];
                e_rs2    = w[24:20];
                e_imm    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                e_alu_op = alu_branch;
                e_branch = br_cond;
                e_flags  = f_pcreg;
            end
            7'b1101111: begin
                e_imm    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                e_branch = br_jal;
                e_flags  = f_pcreg | f_rdsrc | f_rw; // link goes to rd.
            end
            7'b0110111: begin
                e_imm    = {w[31:12], 12'h000};
                e_alu_op = alu_lui;
                e_flags  = f_asrc | f_rw;
            end
            7'b0000111: begin
                e_rs1   = w[19:15];
                e_imm   = {{20{w[31]}}, w[31:20]};
                e_flags = f_asrc | f_m2r | f_mr | f_frw;
            end
            7'b0100111: begin
                e_rs1   = w[19:15];
                e_rs2   = w[24:20];
                e_imm   = {{20{w[31]}}, w[31:25], w[11:7]};
                e_flags = f_ufrs2 | f_asrc | f_mw | f_minf;
            end
            7'b1010011: begin
                e_rs1   = w[19:15];
                e_rs2   = w[24:20];
                e_flags = f_ufrs1 | f_ufrs2 | f_frw | f_self | f_isf;
            end
            default: ; // unknown opcode decodes to a nop.
        endcase
    endtask

    task automatic check_stage(input logic [31:0] pcv, d1, d2, d3, d4);
        check_val("ex_pc", 64'(ex_pc), 64'(pcv));
        check_val("ex_rs1_data", 64'(ex_rs1_data), 64'(d1));
        check_val("ex_rs2_data", 64'(ex_rs2_data), 64'(d2));
        check_val("ex_frs1_data", 64'(ex_frs1_data), 64'(d3));
        check_val("ex_frs2_data", 64'(ex_frs2_data), 64'(d4));
        check_val("ex_rs1_addr", 64'(ex_rs1_addr), 64'(e_rs1));
        check_val("ex_rs2_addr", 64'(ex_rs2_addr), 64'(e_rs2));
        check_val("ex_rd_addr", 64'(ex_rd_addr), 64'(e_rd));
        check_val("ex_funct3", 64'(ex_funct3), 64'(e_f3));
        check_val("ex_funct7", 64'(ex_funct7), 64'(e_f7));
        check_val("ex_imm", 64'(ex_imm), 64'(e_imm));
        check_val("ex_alu_op", 64'(ex_alu_op), 64'(e_alu_op));
        check_val("ex_branch", 64'(ex_branch), 64'(e_branch));
        check_val("ex_uses_frs1", 64'(ex_uses_frs1), 64'(e_flags[12]));
        check_val("ex_uses_frs2", 64'(ex_uses_frs2), 64'(e_flags[11]));
        check_val("ex_alu_src", 64'(ex_alu_src), 64'(e_flags[10]));
        check_val("ex_pc_to_reg", 64'(ex_pc_to_reg), 64'(e_flags[9]));
        check_val("ex_rd_src", 64'(ex_rd_src), 64'(e_flags[8]));
        check_val("ex_mem_to_reg", 64'(ex_mem_to_reg), 64'(e_flags[7]));
        check_val("ex_mem_write", 64'(ex_mem_write), 64'(e_flags[6]));
        check_val("ex_mem_read", 64'(ex_mem_read), 64'(e_flags[5]));
        check_val("ex_reg_write", 64'(ex_reg_write), 64'(e_flags[4]));
        check_val("ex_freg_write", 64'(ex_freg_write), 64'(e_flags[3]));
        check_val("ex_alu_sel_f", 64'(ex_alu_sel_f), 64'(e_flags[2]));
        check_val("ex_is_float", 64'(ex_is_float), 64'(e_flags[1]));
        check_val("ex_mem_in_f", 64'(ex_mem_in_f), 64'(e_flags[0]));
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    function automatic logic [31:0] make_instr(input int kind, input logic [31:0] r);
        case (kind)
            0:       return {r[31:15], 3'b000, r[11:7], 7'b0010011}; // addi.
            1:       return {r[31:15], 3'b010, r[11:7], 7'b0000011}; // lw.
            2:       return {r[31:15], 3'b010, r[11:7], 7'b0100011}; // sw.
            3:       return {r[31:15], 3'b000, r[11:7], 7'b1100011}; // beq.
            4:       return {r[31:7], 7'b1101111};
            5:       return {r[31:7], 7'b0110111};
            6:       return {r[31:15], 3'b010, r[11:7], 7'b0000111}; // flw.
            7:       return {r[31:15], 3'b010, r[11:7], 7'b0100111}; // fsw.
            default: return {7'b0000000, r[24:15], 3'b111, r[11:7], 7'b1010011}; // fadd.s.
        endcase
    endfunction

    task automatic load_then_use(input logic [4:0] load_rd, input logic [4:0] use_rs1,
                                 input logic exp_stall);
        logic [31:0] add_w;
        add_w = {7'b0, 5'd7, use_rs1, 3'b000, 5'd6, 7'b0110011};
        present({12'h024, 5'd1, 3'b010, load_rd, 7'b0000011}, 1'b0);
        present(add_w, 1'b0);
        @(negedge clk);
        check_val("stall", 64'(stall), 64'(exp_stall));
        if (exp_stall) begin
            @(posedge clk); // fetch holds the add while the bubble goes in.
            @(negedge clk);
            clear_expect();
            check_stage(0, 0, 0, 0, 0);
            check_val("stall", 64'(stall), 64'(0));
        end
        present(32'h0, 1'b0);
        @(negedge clk);
        ref_decode(add_w);
        check_stage(cur_pc, cur_d1, cur_d2, cur_d3, cur_d4);
    endtask

    task automatic count_step(input logic [31:0] w, input logic bt, input int delta);
        @(posedge clk);
        edges = edges + 64'd1;
        if (edges > 64'd2) begin
            sum = sum + 64'(pending);
        end
        instr        <= w;
        branch_taken <= bt;
        pending = delta;
        @(negedge clk);
        check_val("cycle_cnt", cycle_cnt, edges);
        check_val("instr_cnt", instr_cnt, sum);
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        apply_reset();
        @(negedge clk);
        clear_expect();
        check_stage(0, 0, 0, 0, 0);
        check_val("stall", 64'(stall), 64'(0));
        check_val("cycle_cnt", cycle_cnt, 64'd0);
        check_val("instr_cnt", instr_cnt, 64'd0);
        end_test("reset state", err0);
    endtask

    task automatic decode_and_latch();
        int          err0;
        int          i;
        logic [31:0] w;
        logic [31:0] pcv;
        err0 = errors;
        wait_idle();
        for (i = 0; i < 45; i++) begin
            w   = make_instr(i % 9, $urandom);
            pcv = $urandom & 32'hffff_fffc;
            present(w, 1'b0);
            set_operands(pcv, $urandom, $urandom, $urandom, $urandom);
            @(negedge clk);
            check_val("stall", 64'(stall), 64'(0));
            present(32'h0, 1'b0); // filler so a load never meets its own successor.
            @(negedge clk);
            ref_decode(w);
            check_stage(pcv, cur_d1, cur_d2, cur_d3, cur_d4);
        end
        end_test("decode and latch", err0);
    endtask

    task automatic load_use_stall();
        int err0;
        err0 = errors;
        wait_idle();
        present(32'h0, 1'b0);
        set_operands(32'h0000_1040, $urandom, $urandom, $urandom, $urandom);
        load_then_use(5'd5, 5'd5, 1'b1);
        load_then_use(5'd0, 5'd0, 1'b0);
        load_then_use(5'd5, 5'd8, 1'b0);
        end_test("load-use stall", err0);
    endtask

    task automatic flush_on_branch();
        int err0;
        err0 = errors;
        wait_idle();
        present(32'h0, 1'b0);
        set_operands(32'h0000_2000, $urandom, $urandom, $urandom, $urandom);
        present({12'h07f, 5'd3, 3'b000, 5'd4, 7'b0010011}, 1'b1);
        @(negedge clk);
        check_val("stall", 64'(stall), 64'(0));
        present(32'h0, 1'b0);
        @(negedge clk);
        clear_expect();
        check_stage(0, 0, 0, 0, 0);
        present({12'h024, 5'd1, 3'b010, 5'd5, 7'b0000011}, 1'b0);
        present({7'b0, 5'd7, 5'd5, 3'b000, 5'd6, 7'b0110011}, 1'b1);
        @(negedge clk);
        check_val("stall", 64'(stall), 64'(0)); // flush beats load-use.
        present(32'h0, 1'b0);
        @(negedge clk);
        clear_expect();
        check_stage(0, 0, 0, 0, 0);
        end_test("flush", err0);
    endtask

    task automatic counter_sequence();
        int          err0;
        logic [31:0] lw_w;
        logic [31:0] add_w;
        logic [31:0] addi_w;
        err0   = errors;
        lw_w   = {12'h010, 5'd2, 3'b010, 5'd5, 7'b0000011};
        add_w  = {7'b0, 5'd9, 5'd5, 3'b000, 5'd10, 7'b0110011};
        addi_w = {12'h001, 5'd1, 3'b000, 5'd1, 7'b0010011};
        apply_reset();
        edges   = '0;
        sum     = '0;
        pending = 0;
        count_step(32'h0, 1'b0, 1);
        count_step(32'h0, 1'b0, 1);
        count_step(lw_w, 1'b0, 1);
        count_step(add_w, 1'b0, 0);
        count_step(add_w, 1'b0, 1);
        count_step(addi_w, 1'b1, -1);
        count_step(32'h0, 1'b0, 1);
        count_step(lw_w, 1'b0, 1);
        count_step(add_w, 1'b1, -1);
        count_step(32'h0, 1'b1, -1);
        count_step(32'h0, 1'b0, 1);
        count_step(32'h0, 1'b0, 1);
        count_step(32'h0, 1'b0, 1);
        end_test("counters", err0);
    endtask

    initial begin
        void'($urandom(32'hb2390a59));
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        frs1_data    = '0;
        frs2_data    = '0;
        branch_taken = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_state();
        decode_and_latch();
        load_use_stall();
        flush_on_branch();
        counter_sequence();
        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_pipe_slice.f
+incdir+include
design/rv_pipe_pkg.sv
design/id_decoder.sv
design/hazard_unit.sv
design/idexe_reg.sv
design/perf_counters.sv
design/id_stage_top.sv
tb/tb_id_stage.sv

//--- Makefile
TOP = tb_id_stage

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

build:
	verilator --binary --timing --assert -f rv_pipe_slice.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timing -f rv_pipe_slice.f --top-module id_stage_top

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
